// ==== common/sevenseg_pkg.sv ====
// shared bus widths, display word union, register addresses
package sevenseg_pkg;

	// ------------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------------
	// one word on the display bus
	localparam int word_bits = 16;
	// one hex or bcd digit
	localparam int digit_bits = 4;

	// ------------------------------------------------------------------------
	// display word, shifted out as raw or built as address and data
	// ------------------------------------------------------------------------
	typedef union packed {
		logic [word_bits-1:0] raw;
		struct packed {
			// ignored by the display
			logic [3:0] unused;
			logic [3:0] addr;
			logic [7:0] data;
		} fields;
	} disp_word_u;

	// ------------------------------------------------------------------------
	// register addresses
	// ------------------------------------------------------------------------
	// first digit register, lsd
	localparam logic [3:0] reg_digit_base = 4'd1;
	localparam logic [3:0] reg_decode     = 4'd9;
	localparam logic [3:0] reg_intensity  = 4'd10;
	localparam logic [3:0] reg_scan_limit = 4'd11;
	localparam logic [3:0] reg_shutdown   = 4'd12;
	localparam logic [3:0] reg_test       = 4'd15;

endpackage

// ==== src/serial_tx.sv ====
// serial word shifter with half-bit divider and load strobe
`timescale 1ns/1ns

module serial_tx #(
	parameter int clk_div = 2
) (
	input  logic                     slow_clk,
	input  logic                     rst,
	input  logic                     send,
	input  sevenseg_pkg::disp_word_u word,
	output logic                     busy,
	output logic                     seg_dat,
	output logic                     seg_clk,
	output logic                     seg_sel
);
	import sevenseg_pkg::*;

	localparam int div_w = (clk_div > 1) ? $clog2(clk_div) : 1;
	localparam int bit_w = $clog2(word_bits);

	logic [word_bits-1:0] shreg;
	logic [div_w-1:0]     div_cnt;
	logic [bit_w-1:0]     bit_cnt;
	// one cycle after the last bit, before going idle
	logic                 latch;
	logic                 half_end;
	logic                 last_bit;
	logic                 shift_bit;

	assign half_end  = (div_cnt == div_w'(clk_div - 1));
	assign last_bit  = (bit_cnt == bit_w'(word_bits - 1));
	// falling serial clock moves on to the next bit
	assign shift_bit = busy && !latch && half_end && seg_clk;
	// msb first, line low outside a word
	assign seg_dat   = shreg[word_bits-1] & ~seg_sel;

	// ------------------------------------------------------------------------
	// framing, divider, bit counter
	// ------------------------------------------------------------------------
	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			busy    <= 1'b0;
			seg_sel <= 1'b1;
			seg_clk <= 1'b0;
			latch   <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (send) begin
				busy    <= 1'b1;
				seg_sel <= 1'b0;
				div_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (latch) begin
			busy  <= 1'b0;
			latch <= 1'b0;
		end else begin
			div_cnt <= half_end ? '0 : div_cnt + 1'b1;
			if (half_end) begin
				seg_clk <= ~seg_clk;
				// end of a high phase
				if (seg_clk && last_bit) begin
					seg_sel <= 1'b1;
					latch   <= 1'b1;
				end else if (seg_clk) begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// shift register
	always_ff @(posedge slow_clk) begin
		if (send && !busy)
			shreg <= word.raw;
		else if (shift_bit && !last_bit)
			shreg <= {shreg[word_bits-2:0], 1'b0};
	end

endmodule

// ==== src/bcd_conv.sv ====
// iterative double-dabble binary to bcd converter
`timescale 1ns/1ns

module bcd_conv #(
	parameter int ctr_bits   = 24,
	parameter int num_digits = 8
) (
	input  logic                                          slow_clk,
	input  logic                                          rst,
	input  logic                                          start,
	input  logic [ctr_bits-1:0]                           value,
	output logic [num_digits*sevenseg_pkg::digit_bits-1:0] bcd,
	output logic                                          bcd_done
);
	import sevenseg_pkg::*;

	localparam int bcd_bits = num_digits * digit_bits;
	localparam int cnt_w    = $clog2(ctr_bits + 1);

	logic [ctr_bits-1:0] sh;
	logic [bcd_bits-1:0] acc;
	logic [bcd_bits-1:0] adj;
	logic [bcd_bits-1:0] acc_nxt;
	logic [cnt_w-1:0]    cnt;
	logic                running;
	logic                last;

	// add three to every digit of five or more
	always_comb begin
		adj = acc;
		for (int i = 0; i < num_digits; i++) begin
			if (acc[i*digit_bits +: digit_bits] >= digit_bits'(5))
				adj[i*digit_bits +: digit_bits] = acc[i*digit_bits +: digit_bits] + digit_bits'(3);
		end
	end

	// then shift in the next input bit
	assign acc_nxt = {adj[bcd_bits-2:0], sh[ctr_bits-1]};
	assign last    = running && (cnt == cnt_w'(1));

	// ------------------------------------------------------------------------
	// bit counter, restarted by every start
	// ------------------------------------------------------------------------
	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			running  <= 1'b0;
			cnt      <= '0;
			bcd_done <= 1'b0;
		end else begin
			bcd_done <= last && !start;
			if (start) begin
				running <= 1'b1;
				cnt     <= cnt_w'(ctr_bits);
			end else if (running) begin
				cnt <= cnt - 1'b1;
				if (last)
					running <= 1'b0;
			end
		end
	end

	// datapath, digits only change on completion
	always_ff @(posedge slow_clk) begin
		if (start) begin
			sh  <= value;
			acc <= '0;
		end else if (running) begin
			sh  <= sh << 1;
			acc <= acc_nxt;
		end
		if (last && !start)
			bcd <= acc_nxt;
	end

endmodule

// ==== display/disp_cfg.sv ====
// step counter, hex and hold mode registers, new value strobe
`timescale 1ns/1ns

module disp_cfg #(
	parameter int ctr_bits = 24
) (
	input  logic                slow_clk,
	input  logic                rst,
	input  logic                step,
	input  logic                hex_toggle,
	input  logic                hold_toggle,
	output logic [ctr_bits-1:0] value,
	output logic                value_new,
	output logic                show_hex,
	output logic                hold
);

	// ------------------------------------------------------------------------
	// counter, keeps counting in hold
	// ------------------------------------------------------------------------
	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst)
			value <= '0;
		else if (step)
			value <= value + ctr_bits'(1);
	end

	// ------------------------------------------------------------------------
	// mode flags
	// ------------------------------------------------------------------------
	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			show_hex <= 1'b0;
			hold     <= 1'b0;
		end else begin
			// toggles are clean single pulses
			if (hex_toggle)
				show_hex <= ~show_hex;
			if (hold_toggle)
				hold <= ~hold;
		end
	end

	// new content strobe, same cycle as the updated value
	// frozen while hold is set
	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst)
			value_new <= 1'b0;
		else
			value_new <= (step | hex_toggle) & ~hold;
	end

endmodule

// ==== display/disp_ctrl.sv ====
// init sequence, frame sequencing, seven segment font
`timescale 1ns/1ns

module disp_ctrl #(
	parameter int num_digits = 8
) (
	input  logic                                          slow_clk,
	input  logic                                          rst,
	input  logic                                          value_new,
	input  logic                                          bcd_done,
	input  logic                                          show_hex,
	input  logic [num_digits*sevenseg_pkg::digit_bits-1:0] value,
	input  logic [num_digits*sevenseg_pkg::digit_bits-1:0] bcd,
	input  logic                                          busy,
	output logic                                          send,
	output sevenseg_pkg::disp_word_u                      word
);
	import sevenseg_pkg::*;

	localparam int idx_w = $clog2((num_digits > 5) ? num_digits : 5);
	localparam logic [1:0] st_init = 2'd0, st_idle = 2'd1, st_frame = 2'd2;

	logic [1:0]                       state;
	logic [idx_w-1:0]                 idx;
	logic                             pending;
	logic                             req;
	logic                             can_send;
	logic                             frame_start;
	logic [num_digits*digit_bits-1:0] digits;
	disp_word_u                       word_nxt;

	// segment order dp a b c d e f g
	function automatic logic [7:0] font(input logic [3:0] d);
		case (d)
			4'h0: font = 8'h7e;
			4'h1: font = 8'h30;
			4'h2: font = 8'h6d;
			4'h3: font = 8'h79;
			4'h4: font = 8'h33;
			4'h5: font = 8'h5b;
			4'h6: font = 8'h5f;
			4'h7: font = 8'h70;
			4'h8: font = 8'h7f;
			4'h9: font = 8'h7b;
			4'ha: font = 8'h77;
			4'hb: font = 8'h1f;
			4'hc: font = 8'h4e;
			4'hd: font = 8'h3d;
			4'he: font = 8'h4f;
			default: font = 8'h47;
		endcase
	endfunction

	// hex content on every new value, decimal once converted
	assign req         = show_hex ? value_new : bcd_done;
	// one word in flight, wait for busy to rise
	assign can_send    = !busy && !send && (state != st_idle);
	assign frame_start = (state == st_idle) && (pending || req);

	always_comb begin
		word_nxt.fields.unused = '0;
		word_nxt.fields.addr   = reg_digit_base + 4'(idx);
		word_nxt.fields.data   = font(digits[idx*digit_bits +: digit_bits]);
		if (state == st_init) begin
			case (idx)
				0: word_nxt.fields = '{4'd0, reg_decode, 8'h00};
				1: word_nxt.fields = '{4'd0, reg_intensity, 8'h07};
				2: word_nxt.fields = '{4'd0, reg_scan_limit, 8'(num_digits - 1)};
				3: word_nxt.fields = '{4'd0, reg_shutdown, 8'h01};
				default: word_nxt.fields = '{4'd0, reg_test, 8'h00};
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------------------
	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			state   <= st_init;
			idx     <= '0;
			pending <= 1'b0;
			send    <= 1'b0;
		end else begin
			send <= can_send;
			// merged requests, latest content wins
			if (req)
				pending <= 1'b1;
			if (frame_start) begin
				pending <= 1'b0;
				state   <= st_frame;
				idx     <= '0;
			end else if (can_send && state == st_init && idx == idx_w'(4)) begin
				state <= st_idle;
				idx   <= '0;
			end else if (can_send && idx == idx_w'(num_digits - 1)) begin
				state <= st_idle;
				idx   <= '0;
			end else if (can_send) begin
				idx <= idx + 1'b1;
			end
		end
	end

	// digits latched at frame start
	always_ff @(posedge slow_clk) begin
		if (frame_start)
			digits <= show_hex ? value : bcd;
		if (can_send)
			word <= word_nxt;
	end

endmodule

// ==== src/sevenseg_top.sv ====
// top level, config, bcd converter, display controller, serial bus
`timescale 1ns/1ns

module sevenseg_top #(
	parameter int ctr_bits   = 24,
	parameter int num_digits = 8,
	parameter int clk_div    = 2
) (
	input  logic slow_clk,
	input  logic rst,
	input  logic step,
	input  logic hex_toggle,
	input  logic hold_toggle,
	output logic seg_dat,
	output logic seg_clk,
	output logic seg_sel,
	output logic show_hex,
	output logic hold
);
	import sevenseg_pkg::*;

	localparam int disp_bits = num_digits * digit_bits;

	logic [ctr_bits-1:0]  value;
	logic                 value_new;
	logic [disp_bits-1:0] bcd;
	logic                 bcd_done;
	logic                 send;
	logic                 busy;
	disp_word_u           word;

	// ------------------------------------------------------------------------
	// counter and modes
	// ------------------------------------------------------------------------
	disp_cfg #(.ctr_bits(ctr_bits)) i_disp_cfg (
		.slow_clk(slow_clk), .rst(rst), .step(step),
		.hex_toggle(hex_toggle), .hold_toggle(hold_toggle),
		.value(value), .value_new(value_new), .show_hex(show_hex), .hold(hold)
	);

	// decimal digits
	bcd_conv #(.ctr_bits(ctr_bits), .num_digits(num_digits)) i_bcd_conv (
		.slow_clk(slow_clk), .rst(rst), .start(value_new), .value(value),
		.bcd(bcd), .bcd_done(bcd_done)
	);

	// ------------------------------------------------------------------------
	// display words and serial bus
	// ------------------------------------------------------------------------
	disp_ctrl #(.num_digits(num_digits)) i_disp_ctrl (
		.slow_clk(slow_clk), .rst(rst), .value_new(value_new), .bcd_done(bcd_done),
		.show_hex(show_hex), .value(disp_bits'(value)), .bcd(bcd),
		.busy(busy), .send(send), .word(word)
	);

	serial_tx #(.clk_div(clk_div)) i_serial_tx (
		.slow_clk(slow_clk), .rst(rst), .send(send), .word(word), .busy(busy),
		.seg_dat(seg_dat), .seg_clk(seg_clk), .seg_sel(seg_sel)
	);

endmodule

// ==== verif/sevenseg_checker.sv ====
// serial bus and send handshake assertions, bound into serial_tx
`timescale 1ns/1ns

module sevenseg_checker (
	input logic slow_clk,
	input logic rst,
	input logic send,
	input logic busy,
	input logic seg_dat,
	input logic seg_clk,
	input logic seg_sel
);

	// ------------------------------------------------------------------------
	// bus framing
	// ------------------------------------------------------------------------
	// serial clock idles low outside a word
	sel_high_clk_low: assert property (@(posedge slow_clk) disable iff (rst)
		seg_sel |-> !seg_clk)
		else $error("seg_clk high while seg_sel is high");

	// data only moves on a falling serial clock
	dat_stable_clk_high: assert property (@(posedge slow_clk) disable iff (rst)
		(seg_clk && $past(seg_clk)) |-> $stable(seg_dat))
		else $error("seg_dat changed during seg_clk high phase");

	// one word in flight at a time
	no_send_when_busy: assert property (@(posedge slow_clk) disable iff (rst)
		busy |-> !send)
		else $error("send asserted while busy");

endmodule

bind serial_tx sevenseg_checker i_sevenseg_checker (
	.slow_clk(slow_clk), .rst(rst), .send(send), .busy(busy),
	.seg_dat(seg_dat), .seg_clk(seg_clk), .seg_sel(seg_sel)
);

// ==== verif/sevenseg_tb.sv ====
// clock, reset, serial word decoder, directed tests, compare tasks, watchdog
`timescale 1ns/1ns

module sevenseg_tb;
	import sevenseg_pkg::*;

	localparam int ctr_bits    = 24;
	localparam int num_digits  = 8;
	localparam int clk_div     = 2;
	// one bus word plus controller turnaround
	localparam int word_cycles = 32 * clk_div + 4;
	localparam int pop_limit   = 4 * word_cycles;
	localparam int n_tests     = 5;
	localparam int max_frames  = 10;
	// decimal bursts, long enough for several digits
	localparam int dec_bursts  = 3;
	localparam int max_burst   = 2000;
	localparam int watchdog_ns =
		(n_tests * max_frames * num_digits * word_cycles + dec_bursts * max_burst) * 4 * 2;

	logic slow_clk;
	logic rst;
	logic step;
	logic hex_toggle;
	logic hold_toggle;
	logic seg_dat;
	logic seg_clk;
	logic seg_sel;
	logic show_hex;
	logic hold;

	disp_word_u           rx_q[$];
	disp_word_u           rx_word;
	logic [word_bits-1:0] rx_shift;
	int                   rx_bits = 0;
	int                   value_errs = 0;
	int                   other_errs = 0;
	int                   count = 0;
	int                   seed = 32'h9bba;
	// segment order dp a b c d e f g
	logic [7:0] font_tab [16] = '{8'h7e, 8'h30, 8'h6d, 8'h79, 8'h33, 8'h5b, 8'h5f, 8'h70,
		8'h7f, 8'h7b, 8'h77, 8'h1f, 8'h4e, 8'h3d, 8'h4f, 8'h47};

	sevenseg_top #(.ctr_bits(ctr_bits), .num_digits(num_digits), .clk_div(clk_div))
	i_sevenseg_top (
		.slow_clk(slow_clk), .rst(rst), .step(step), .hex_toggle(hex_toggle),
		.hold_toggle(hold_toggle), .seg_dat(seg_dat), .seg_clk(seg_clk),
		.seg_sel(seg_sel), .show_hex(show_hex), .hold(hold)
	);

	initial begin
		slow_clk = 1'b0;
		forever #2 slow_clk = ~slow_clk;
	end

	// ------------------------------------------------------------------------
	// serial decoder, msb first, word latched on seg_sel rise
	// ------------------------------------------------------------------------
	always @(posedge seg_clk) begin
		rx_shift = {rx_shift[word_bits-2:0], seg_dat};
		rx_bits++;
	end

	always @(posedge seg_sel) begin
		if (rx_bits == word_bits) begin
			rx_word.raw = rx_shift;
			rx_q.push_back(rx_word);
		end else if (rx_bits != 0) begin
			$display("word with %0d bits instead of %0d at %0t", rx_bits, word_bits, $time);
			other_errs++;
		end
		rx_bits = 0;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, tests did not finish", watchdog_ns);
		$display("Regression failed");
		$finish;
	end

	// ------------------------------------------------------------------------
	// compare tasks and expected words
	// ------------------------------------------------------------------------
	task automatic check_word(input string name, input disp_word_u exp, input disp_word_u act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp.raw, act.raw);
			value_errs++;
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
			value_errs++;
		end
	endtask

	function automatic disp_word_u make_word(input logic [3:0] addr, input logic [7:0] data);
		disp_word_u w;
		w.raw = {4'h0, addr, data};
		return w;
	endfunction

	// digit at position pos, 0 is least significant
	function automatic logic [3:0] digit_of(input int value, input bit hex, input int pos);
		int v;
		v = value;
		for (int i = 0; i < pos; i++)
			v = hex ? v / 16 : v / 10;
		return hex ? 4'(v % 16) : 4'(v % 10);
	endfunction

	task automatic pop_word(output disp_word_u w, output bit ok);
		int waited;
		waited = 0;
		while (rx_q.size() == 0 && waited < pop_limit) begin
			@(posedge slow_clk);
			waited++;
		end
		ok = (rx_q.size() != 0);
		w = ok ? rx_q.pop_front() : '0;
		if (!ok) begin
			$display("no display word arrived within %0d cycles at %0t", pop_limit, $time);
			other_errs++;
		end
	endtask

	task automatic expect_frame(input int value, input bit hex);
		disp_word_u got;
		bit         ok;
		for (int a = 1; a <= num_digits; a++) begin
			pop_word(got, ok);
			if (!ok)
				return;
			check_word($sformatf("digit word %0d", a),
				make_word(4'(a), font_tab[digit_of(value, hex, a - 1)]), got);
		end
	endtask

	// wait until the bus has been silent for three word times
	task automatic wait_quiet();
		int last;
		last = -1;
		while (rx_q.size() != last) begin
			last = rx_q.size();
			repeat (3 * word_cycles) @(posedge slow_clk);
		end
	endtask

	// ------------------------------------------------------------------------
	// stimulus, driven 1 ns after the rising edge
	// ------------------------------------------------------------------------
	task automatic step_burst(input int n);
		@(posedge slow_clk);
		#1 step = 1'b1;
		repeat (n) @(posedge slow_clk);
		#1 step = 1'b0;
		count += n;
	endtask

	task automatic toggle_hex();
		@(posedge slow_clk);
		#1 hex_toggle = 1'b1;
		@(posedge slow_clk);
		#1 hex_toggle = 1'b0;
	endtask

	task automatic toggle_hold();
		@(posedge slow_clk);
		#1 hold_toggle = 1'b1;
		@(posedge slow_clk);
		#1 hold_toggle = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic test_reset_init();
		disp_word_u got;
		bit         ok;
		disp_word_u exp [5];
		exp = '{make_word(reg_decode, 8'h00), make_word(reg_intensity, 8'h07),
			make_word(reg_scan_limit, 8'(num_digits - 1)), make_word(reg_shutdown, 8'h01),
			make_word(reg_test, 8'h00)};
		check_level("seg_sel", 1'b1, seg_sel);
		check_level("seg_clk", 1'b0, seg_clk);
		check_level("show_hex", 1'b0, show_hex);
		check_level("hold", 1'b0, hold);
		for (int i = 0; i < 5; i++) begin
			pop_word(got, ok);
			if (ok)
				check_word($sformatf("init word %0d", i), exp[i], got);
		end
	endtask

	// each burst restarts the converter, so one frame per burst
	task automatic test_decimal();
		int n;
		repeat (dec_bursts) begin
			n = 1 + ($unsigned($random(seed)) % max_burst);
			step_burst(n);
			expect_frame(count, 1'b0);
		end
	endtask

	task automatic test_hex();
		toggle_hex();
		check_level("show_hex", 1'b1, show_hex);
		expect_frame(count, 1'b1);
		repeat (2) begin
			step_burst(1);
			expect_frame(count, 1'b1);
		end
	endtask

	task automatic test_hold();
		toggle_hold();
		check_level("hold", 1'b1, hold);
		repeat (3) step_burst(1);
		wait_quiet();
		if (rx_q.size() != 0) begin
			$display("%0d display words sent while hold was set", rx_q.size());
			other_errs++;
			rx_q.delete();
		end
		toggle_hold();
		check_level("hold", 1'b0, hold);
		step_burst(1);
		expect_frame(count, 1'b1);
	endtask

	// steps back to back while a frame is on the bus
	task automatic test_backpressure();
		int first;
		step_burst(1);
		first = count;
		repeat (2 * word_cycles) @(posedge slow_clk);
		step_burst(6 + ($unsigned($random(seed)) % 10));
		// whole burst merges into a single frame with the final count
		expect_frame(first, 1'b1);
		expect_frame(count, 1'b1);
		wait_quiet();
		if (rx_q.size() != 0) begin
			$display("%0d extra display words after back-pressure", rx_q.size());
			other_errs++;
			rx_q.delete();
		end
	endtask

	initial begin
		rst = 1'b1;
		step = 1'b0;
		hex_toggle = 1'b0;
		hold_toggle = 1'b0;
		repeat (2) @(posedge slow_clk);
		#1 rst = 1'b0;
		test_reset_init();
		test_decimal();
		test_hex();
		test_hold();
		test_backpressure();
		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== src.f ====
common/sevenseg_pkg.sv
src/serial_tx.sv
src/bcd_conv.sv
display/disp_cfg.sv
display/disp_ctrl.sv
src/sevenseg_top.sv
verif/sevenseg_checker.sv
verif/sevenseg_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing --assert
TOP       = sevenseg_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
